/* src/icache_cfg.svh */
// instruction cache configuration
// geometry of the four-way set-associative array and the replacement LFSR seed

`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// byte address and fetch word
`define ICACHE_ADDR_W 32
`define ICACHE_FETCH_W 32

// one line holds four fetch words
`define ICACHE_LINE_W 128

// associativity and number of sets
`define ICACHE_WAYS 4
`define ICACHE_SETS 64

// address split: tag | index | byte offset
`define ICACHE_OFFSET_W 4
`define ICACHE_INDEX_W 6
`define ICACHE_TAG_W 22

// must be nonzero, an all-zero LFSR would lock up
`define ICACHE_LFSR_SEED 4'b1001

`endif

/* src/icache_pkg.sv */
// instruction cache types
// width typedefs shared by the controller, the ways and the hit selector,
// plus the controller state encoding

`include "icache_cfg.svh"

package icache_pkg;

  // address fields
  typedef logic [`ICACHE_ADDR_W-1:0] addr_t;
  typedef logic [`ICACHE_TAG_W-1:0] tag_t;
  typedef logic [`ICACHE_INDEX_W-1:0] index_t;

  // word position inside a line, byte offset without the low two bits
  typedef logic [`ICACHE_OFFSET_W-3:0] word_sel_t;

  // payload
  typedef logic [`ICACHE_LINE_W-1:0] line_t;
  typedef logic [`ICACHE_FETCH_W-1:0] fetch_t;

  // per-way vectors
  typedef logic [`ICACHE_WAYS-1:0] way_vec_t;
  typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_idx_t;

  // controller states
  // FLUSH clears the valid bits one set per cycle
  // IDLE  waits for a request
  // READ  compares tags, returns a hit or issues the refill
  // MISS  waits for the refill line
  typedef enum logic [1:0] {
    FLUSH,
    IDLE,
    READ,
    MISS
  } state_e;

endpackage

/* src/icache_way.sv */
// instruction cache way
// one way's valid bits, tag array and line array with registered reads,
// plus the tag compare for the looked-up set

`timescale 1ns/100ps

`include "icache_cfg.svh"

module icache_way (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               rd_en_i,
  input  logic               wr_en_i,
  input  logic               clr_en_i,
  input  icache_pkg::index_t index_i,
  input  icache_pkg::tag_t   req_tag_i,
  input  icache_pkg::line_t  fill_line_i,
  output logic               hit_o,
  output logic               vld_o,
  output icache_pkg::line_t  line_o
);

  // storage
  logic [`ICACHE_SETS-1:0] vld_q;
  icache_pkg::tag_t        tag_mem [`ICACHE_SETS];
  icache_pkg::line_t       data_mem [`ICACHE_SETS];

  // read registers
  logic                    vld_rd_q;
  icache_pkg::tag_t        tag_rd_q;
  icache_pkg::line_t       line_rd_q;

  //////////////////////////////////////////////////
  // valid bits
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q    <= '0;
      vld_rd_q <= 1'b0;
    end else begin
      // a fill sets the bit, a flush step drops it
      if (wr_en_i) begin
        vld_q[index_i] <= 1'b1;
      end else if (clr_en_i) begin
        vld_q[index_i] <= 1'b0;
      end
      if (rd_en_i) begin
        vld_rd_q <= vld_q[index_i];
      end
    end
  end

  //////////////////////////////////////////////////
  // tag and data arrays
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      tag_mem[index_i]  <= req_tag_i;
      data_mem[index_i] <= fill_line_i;
    end
    // outputs hold until the next lookup
    if (rd_en_i) begin
      tag_rd_q  <= tag_mem[index_i];
      line_rd_q <= data_mem[index_i];
    end
  end

  // compare against the tag of the request being served
  assign hit_o  = vld_rd_q & (tag_rd_q == req_tag_i);
  assign vld_o  = vld_rd_q;
  assign line_o = line_rd_q;

endmodule

/* src/icache_hit_sel.sv */
// instruction cache hit selector
// merges the per-way lookups into the hit flag and the fetch word,
// and finds the lowest invalid way for replacement

`timescale 1ns/100ps

`include "icache_cfg.svh"

module icache_hit_sel (
  input  icache_pkg::way_vec_t  hit_i,
  input  icache_pkg::way_vec_t  vld_i,
  input  icache_pkg::line_t     line_i [`ICACHE_WAYS],
  input  icache_pkg::line_t     fill_line_i,
  input  icache_pkg::word_sel_t word_sel_i,
  input  logic                  fill_sel_i,
  output logic                  any_hit_o,
  output icache_pkg::way_idx_t  inv_way_o,
  output logic                  all_valid_o,
  output icache_pkg::fetch_t    data_o
);

  icache_pkg::line_t  hit_line;
  icache_pkg::line_t  sel_line;
  // the selected line seen as fetch words
  icache_pkg::fetch_t [`ICACHE_LINE_W/`ICACHE_FETCH_W-1:0] sel_words;

  //////////////////////////////////////////////////
  // data path
  //////////////////////////////////////////////////

  // lowest hitting way wins, only one can hit anyway
  always_comb begin
    hit_line = '0;
    for (int i = `ICACHE_WAYS - 1; i >= 0; i--) begin
      if (hit_i[i]) begin
        hit_line = line_i[i];
      end
    end
  end

  // refill data bypasses the arrays
  assign sel_line  = fill_sel_i ? fill_line_i : hit_line;
  assign sel_words = sel_line;
  assign data_o    = sel_words[word_sel_i];

  assign any_hit_o = |hit_i;

  //////////////////////////////////////////////////
  // replacement info
  //////////////////////////////////////////////////

  // scan down so the lowest invalid way is the last one kept
  always_comb begin
    inv_way_o = '0;
    for (int i = `ICACHE_WAYS - 1; i >= 0; i--) begin
      if (!vld_i[i]) begin
        inv_way_o = icache_pkg::way_idx_t'(i);
      end
    end
  end

  assign all_valid_o = &vld_i;

endmodule

/* src/icache_ctrl.sv */
// instruction cache controller
// runs the fetch FSM, holds the request address and pending flush,
// sweeps the valid bits on flush and picks the way to refill

`timescale 1ns/100ps

`include "icache_cfg.svh"

module icache_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // fetch side
  input  logic                 req_i,
  input  icache_pkg::addr_t    addr_i,
  output logic                 ready_o,
  output logic                 valid_o,
  input  logic                 flush_i,
  // refill side
  output logic                 mem_req_o,
  output icache_pkg::addr_t    mem_addr_o,
  input  logic                 mem_ack_i,
  input  logic                 mem_rtrn_vld_i,
  // from the hit selector
  input  logic                 any_hit_i,
  input  icache_pkg::way_idx_t inv_way_i,
  input  logic                 all_valid_i,
  // array control
  output logic                 rd_en_o,
  output logic                 clr_en_o,
  output icache_pkg::way_vec_t wr_en_o,
  output icache_pkg::index_t   index_o,
  output icache_pkg::tag_t     req_tag_o,
  output icache_pkg::word_sel_t word_sel_o,
  output logic                 fill_sel_o
);

  icache_pkg::state_e   state_d, state_q;
  icache_pkg::addr_t    addr_q;
  icache_pkg::index_t   flush_cnt_d, flush_cnt_q;
  icache_pkg::way_vec_t repl_oh_q;
  icache_pkg::way_idx_t rnd_way;
  icache_pkg::way_idx_t repl_way;
  logic                 flush_d, flush_q;
  logic                 flush_done;
  logic                 accept;
  logic                 lfsr_en;
  logic [3:0]           lfsr_q;

  //////////////////////////////////////////////////
  // address split and array addressing
  //////////////////////////////////////////////////

  assign accept = ready_o & req_i;

  // tag and word always refer to the request being served
  assign req_tag_o  = addr_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
  assign word_sel_o = addr_q[`ICACHE_OFFSET_W-1:2];

  // refill requests are always line aligned
  assign mem_addr_o = {addr_q[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};

  // flush sweep, new lookup, or the held request for a fill
  assign index_o = (state_q == icache_pkg::FLUSH) ? flush_cnt_q :
                   accept ? addr_i[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W] :
                            addr_q[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];

  assign flush_done = (flush_cnt_q == icache_pkg::index_t'(`ICACHE_SETS - 1));

  //////////////////////////////////////////////////
  // main FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    flush_d     = flush_q | flush_i;
    flush_cnt_d = flush_cnt_q;
    ready_o     = 1'b0;
    valid_o     = 1'b0;
    mem_req_o   = 1'b0;
    rd_en_o     = 1'b0;
    clr_en_o    = 1'b0;
    wr_en_o     = '0;
    fill_sel_o  = 1'b0;
    lfsr_en     = 1'b0;

    unique case (state_q)
      icache_pkg::FLUSH: begin
        // one set per cycle
        clr_en_o    = 1'b1;
        flush_cnt_d = flush_cnt_q + 1'b1;
        if (flush_done) begin
          state_d     = icache_pkg::IDLE;
          flush_d     = 1'b0;
          flush_cnt_d = '0;
        end
      end
      icache_pkg::IDLE: begin
        if (flush_d) begin
          state_d = icache_pkg::FLUSH;
        end else begin
          ready_o = 1'b1;
          if (req_i) begin
            rd_en_o = 1'b1;
            state_d = icache_pkg::READ;
          end
        end
      end
      icache_pkg::READ: begin
        if (any_hit_i) begin
          valid_o = 1'b1;
          state_d = icache_pkg::IDLE;
          // take the next request right away unless a flush waits
          if (!flush_d) begin
            ready_o = 1'b1;
            if (req_i) begin
              rd_en_o = 1'b1;
              state_d = icache_pkg::READ;
            end
          end
        end else begin
          // miss, hold the refill request until memory takes it
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            state_d = icache_pkg::MISS;
          end
        end
      end
      icache_pkg::MISS: begin
        // word comes straight from the returned line
        fill_sel_o = 1'b1;
        if (mem_rtrn_vld_i) begin
          valid_o = 1'b1;
          wr_en_o = repl_oh_q;
          lfsr_en = all_valid_i;
          state_d = icache_pkg::IDLE;
        end
      end
      default: begin
        state_d = icache_pkg::FLUSH;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // replacement
  //////////////////////////////////////////////////

  // 4-bit maximal LFSR, x^4 + x^3 + 1
  assign rnd_way  = lfsr_q[$bits(icache_pkg::way_idx_t)-1:0];
  assign repl_way = all_valid_i ? rnd_way : inv_way_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= icache_pkg::FLUSH;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
      repl_oh_q   <= '0;
      lfsr_q      <= `ICACHE_LFSR_SEED;
    end else begin
      state_q     <= state_d;
      flush_q     <= flush_d;
      flush_cnt_q <= flush_cnt_d;
      // way choice is settled while the tags are compared
      if (state_q == icache_pkg::READ) begin
        repl_oh_q <= icache_pkg::way_vec_t'(1) << repl_way;
      end
      if (lfsr_en) begin
        lfsr_q <= {lfsr_q[2:0], lfsr_q[3] ^ lfsr_q[2]};
      end
    end
  end

  // request address, loaded on accept
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= addr_i;
    end
  end

endmodule

/* src/icache_top.sv */
// instruction cache top level
// four-way set-associative cache, controller plus one array per way
// and a hit selector that merges the way results

`timescale 1ns/100ps

`include "icache_cfg.svh"

module icache_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  // fetch side
  input  logic               req_i,
  input  icache_pkg::addr_t  addr_i,
  output logic               ready_o,
  output logic               valid_o,
  output icache_pkg::fetch_t data_o,
  input  logic               flush_i,
  // refill side
  output logic               mem_req_o,
  output icache_pkg::addr_t  mem_addr_o,
  input  logic               mem_ack_i,
  input  logic               mem_rtrn_vld_i,
  input  icache_pkg::line_t  mem_rtrn_data_i
);

  // controller to arrays
  logic                  rd_en;
  logic                  clr_en;
  icache_pkg::way_vec_t  wr_en;
  icache_pkg::index_t    index;
  icache_pkg::tag_t      req_tag;
  icache_pkg::word_sel_t word_sel;
  logic                  fill_sel;

  // arrays to hit selector
  icache_pkg::way_vec_t  way_hit;
  icache_pkg::way_vec_t  way_vld;
  icache_pkg::line_t     way_line [`ICACHE_WAYS];

  // hit selector to controller
  logic                  any_hit;
  icache_pkg::way_idx_t  inv_way;
  logic                  all_valid;

  icache_ctrl icache_ctrl_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .addr_i         (addr_i),
    .ready_o        (ready_o),
    .valid_o        (valid_o),
    .flush_i        (flush_i),
    .mem_req_o      (mem_req_o),
    .mem_addr_o     (mem_addr_o),
    .mem_ack_i      (mem_ack_i),
    .mem_rtrn_vld_i (mem_rtrn_vld_i),
    .any_hit_i      (any_hit),
    .inv_way_i      (inv_way),
    .all_valid_i    (all_valid),
    .rd_en_o        (rd_en),
    .clr_en_o       (clr_en),
    .wr_en_o        (wr_en),
    .index_o        (index),
    .req_tag_o      (req_tag),
    .word_sel_o     (word_sel),
    .fill_sel_o     (fill_sel)
  );

  // one array per way, all share the lookup, each has its own write enable
  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : gen_way
    icache_way icache_way_i (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .rd_en_i     (rd_en),
      .wr_en_i     (wr_en[w]),
      .clr_en_i    (clr_en),
      .index_i     (index),
      .req_tag_i   (req_tag),
      .fill_line_i (mem_rtrn_data_i),
      .hit_o       (way_hit[w]),
      .vld_o       (way_vld[w]),
      .line_o      (way_line[w])
    );
  end

  icache_hit_sel icache_hit_sel_i (
    .hit_i       (way_hit),
    .vld_i       (way_vld),
    .line_i      (way_line),
    .fill_line_i (mem_rtrn_data_i),
    .word_sel_i  (word_sel),
    .fill_sel_i  (fill_sel),
    .any_hit_o   (any_hit),
    .inv_way_o   (inv_way),
    .all_valid_o (all_valid),
    .data_o      (data_o)
  );

endmodule

/* bench/icache_properties.sv */
// instruction cache protocol checks
// concurrent assertions on reset sweep, refill address, hit latency and flush

`timescale 1ns/100ps

`include "icache_cfg.svh"

module icache_properties (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              req_i,
  input icache_pkg::addr_t addr_i,
  input logic              flush_i,
  input logic              ready_o,
  input logic              valid_o,
  input logic              mem_req_o,
  input icache_pkg::addr_t mem_addr_o,
  input logic              mem_ack_i
);

  localparam int LINE_NUM_W = `ICACHE_ADDR_W - `ICACHE_OFFSET_W;

  int                    fail_cnt;
  int unsigned           sweep_cnt_q;
  icache_pkg::addr_t     acc_addr_q;
  logic [LINE_NUM_W-1:0] fill_line_q;
  logic                  fill_vld_q;
  logic                  after_flush_q;
  logic                  accept;

  initial fail_cnt = 0;

  assign accept = req_i & ready_o;

  //////////////////////////////////////////////////
  // tracking of the request, the last fill and flushes
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sweep_cnt_q   <= 0;
      acc_addr_q    <= '0;
      fill_line_q   <= '0;
      fill_vld_q    <= 1'b0;
      after_flush_q <= 1'b0;
    end else begin
      // cycles since reset, saturating after the sweep
      if (sweep_cnt_q != `ICACHE_SETS) begin
        sweep_cnt_q <= sweep_cnt_q + 1;
      end
      if (accept) begin
        acc_addr_q <= addr_i;
      end
      if (flush_i) begin
        fill_vld_q    <= 1'b0;
        after_flush_q <= 1'b1;
      end else begin
        // line taken by memory is the next one written
        if (mem_req_o && mem_ack_i) begin
          fill_line_q <= mem_addr_o[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W];
          fill_vld_q  <= 1'b1;
        end
        if (accept) begin
          after_flush_q <= 1'b0;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // properties
  //////////////////////////////////////////////////

  a_reset_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (sweep_cnt_q < `ICACHE_SETS) |-> (!ready_o && !mem_req_o && !valid_o))
    else begin
      fail_cnt++;
      $error("cache became active during the reset sweep");
    end

  a_ready_after_sweep: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (sweep_cnt_q == `ICACHE_SETS - 1) |=> ready_o)
    else begin
      fail_cnt++;
      $error("cache not ready once the reset sweep ended");
    end

  a_refill_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o |-> (mem_addr_o == {acc_addr_q[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W],
                                  {`ICACHE_OFFSET_W{1'b0}}}))
    else begin
      fail_cnt++;
      $error("refill address is not the aligned line of the request");
    end

  a_refill_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_o && !mem_ack_i) |=> (mem_req_o && $stable(mem_addr_o)))
    else begin
      fail_cnt++;
      $error("refill request dropped or address moved before the ack");
    end

  a_hit_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (accept && fill_vld_q && !after_flush_q &&
     addr_i[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W] == fill_line_q)
    |=> (valid_o && !mem_req_o))
    else begin
      fail_cnt++;
      $error("request to the line just filled did not hit in one cycle");
    end

  a_flush_miss: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (accept && after_flush_q) |=> (mem_req_o && !valid_o))
    else begin
      fail_cnt++;
      $error("first request after a flush did not go to memory");
    end

endmodule

bind icache_top icache_properties icache_properties_i (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .req_i      (req_i),
  .addr_i     (addr_i),
  .flush_i    (flush_i),
  .ready_o    (ready_o),
  .valid_o    (valid_o),
  .mem_req_o  (mem_req_o),
  .mem_addr_o (mem_addr_o),
  .mem_ack_i  (mem_ack_i)
);

/* bench/icache_tb.sv */
// instruction cache testbench
// drives fetches through fill, hit, set thrash, flush and random traffic,
// models the refill memory and checks every returned word

`timescale 1ns/100ps

`include "icache_cfg.svh"

module icache_tb;

  localparam int CLK_HALF = 4;
  // requests issued by each test
  localparam int N_FILL   = 6;
  localparam int N_THRASH = 12;
  localparam int N_FLUSH  = 4;
  localparam int N_RANDOM = 40;
  localparam int N_REQ    = N_FILL + N_THRASH + N_FLUSH + N_RANDOM;
  // 200 cycles per request plus the reset and flush sweeps
  localparam int WATCHDOG_CYC = N_REQ * 200 + 2 * `ICACHE_SETS + 8;

  logic               clk_i;
  logic               rst_ni;
  logic               req_i;
  icache_pkg::addr_t  addr_i;
  logic               flush_i;
  logic               mem_ack_i;
  logic               mem_rtrn_vld_i;
  icache_pkg::line_t  mem_rtrn_data_i;
  logic               ready_o;
  logic               valid_o;
  icache_pkg::fetch_t data_o;
  logic               mem_req_o;
  icache_pkg::addr_t  mem_addr_o;

  // accepted addresses in order of issue
  icache_pkg::addr_t  pending[$];
  icache_pkg::addr_t  exp_addr;
  int                 errors = 0;
  int                 checks = 0;
  int                 issued = 0;
  int                 tests = 0;

  icache_top icache_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // reference data
  //////////////////////////////////////////////////

  // every memory word is its word aligned address xor a constant
  function automatic icache_pkg::fetch_t expected_word(input icache_pkg::addr_t a);
    return {a[`ICACHE_ADDR_W-1:2], 2'b00} ^ 32'h5a5a_5a5a;
  endfunction

  function automatic icache_pkg::line_t make_line(input icache_pkg::addr_t base);
    icache_pkg::line_t l;
    for (int i = 0; i < `ICACHE_LINE_W / `ICACHE_FETCH_W; i++) begin
      l[i*`ICACHE_FETCH_W +: `ICACHE_FETCH_W] = expected_word(base + 4 * i);
    end
    return l;
  endfunction

  function automatic int error_total();
    return errors + icache_top_i.icache_properties_i.fail_cnt;
  endfunction

  //////////////////////////////////////////////////
  // memory model
  //////////////////////////////////////////////////

  initial begin : refill_memory
    icache_pkg::addr_t line_addr;
    int unsigned       dly;
    forever begin
      @(posedge clk_i);
      if (mem_req_o) begin
        line_addr = mem_addr_o;
        dly = $urandom_range(2, 0);
        repeat (dly) @(posedge clk_i);
        mem_ack_i <= 1'b1;
        @(posedge clk_i);
        mem_ack_i <= 1'b0;
        // line comes 1 to 4 cycles after the ack
        dly = $urandom_range(4, 1);
        repeat (dly - 1) @(posedge clk_i);
        mem_rtrn_data_i <= make_line(line_addr);
        mem_rtrn_vld_i  <= 1'b1;
        @(posedge clk_i);
        mem_rtrn_vld_i  <= 1'b0;
      end
    end
  end

  // each returned word against the oldest accepted address
  always @(posedge clk_i) begin
    if (rst_ni && valid_o) begin
      if (pending.size() == 0) begin
        errors++;
        $display("valid_o pulsed with no request in flight at %0t ns", $time);
      end else begin
        exp_addr = pending.pop_front();
        checks++;
        assert (data_o == expected_word(exp_addr)) else begin
          errors++;
          $display("Error %0t ns: data_o %h for address %h, expected %h",
                   $time, data_o, exp_addr, expected_word(exp_addr));
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  // one fetch from request to the returned word
  task automatic fetch(input icache_pkg::addr_t a);
    req_i  <= 1'b1;
    addr_i <= a;
    @(posedge clk_i);
    while (!ready_o) @(posedge clk_i);
    pending.push_back(a);
    issued++;
    req_i <= 1'b0;
    @(posedge clk_i);
    while (!valid_o) @(posedge clk_i);
  endtask

  task automatic pulse_flush();
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
  endtask

  task automatic log_result(input string name, input int err_before);
    @(posedge clk_i);
    tests++;
    if (error_total() == err_before) begin
      $display("test %-10s ok", name);
    end else begin
      $display("test %-10s FAILED with %0d errors", name, error_total() - err_before);
    end
  endtask

  initial begin : watchdog
    #(WATCHDOG_CYC * 2 * CLK_HALF);
    $display("timeout, the cache stopped answering after %0d requests", issued);
    $display("Done: errors found");
    $finish;
  end

  initial begin : main
    icache_pkg::addr_t a;
    int                err_before;
    void'($urandom(32'h652f));
    rst_ni          <= 1'b0;
    req_i           <= 1'b0;
    addr_i          <= '0;
    flush_i         <= 1'b0;
    mem_ack_i       <= 1'b0;
    mem_rtrn_vld_i  <= 1'b0;
    mem_rtrn_data_i <= '0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;

    // wait out the reset sweep
    err_before = error_total();
    @(posedge clk_i);
    while (!ready_o) @(posedge clk_i);
    log_result("reset", err_before);

    // miss then hits to the same line and then a second line
    err_before = error_total();
    for (int i = 0; i < 4; i++) begin
      fetch(32'h0000_2040 + 4 * i);
    end
    fetch(32'h0000_3058);
    fetch(32'h0000_3050);
    log_result("fill_hit", err_before);

    // six tags in set 13 visited twice
    err_before = error_total();
    for (int r = 0; r < 2; r++) begin
      for (int t = 0; t < 6; t++) begin
        a = {22'h00_0100 + 22'(t * 7), 6'd13, 2'($urandom_range(3, 0)), 2'b00};
        fetch(a);
      end
    end
    log_result("thrash", err_before);

    // a hitting line misses again after a flush
    err_before = error_total();
    fetch(32'h0001_8a24);
    fetch(32'h0001_8a24);
    pulse_flush();
    fetch(32'h0001_8a24);
    fetch(32'h0001_8a2c);
    log_result("flush", err_before);

    // random words from 16 sets and 6 tags
    err_before = error_total();
    for (int i = 0; i < N_RANDOM; i++) begin
      a = 32'h0001_0000 + ($urandom_range(5, 0) << 10) +
          ($urandom_range(15, 0) << 4) + ($urandom_range(3, 0) << 2);
      fetch(a);
    end
    log_result("random", err_before);

    repeat (4) @(posedge clk_i);
    $display("%0d tests, %0d requests, %0d data checks, %0d errors",
             tests, issued, checks, error_total());
    if (error_total() == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* icache.f */
+incdir+src
src/icache_pkg.sv
src/icache_way.sv
src/icache_hit_sel.sv
src/icache_ctrl.sv
src/icache_top.sv
bench/icache_properties.sv
bench/icache_tb.sv

/* run.sh */
#!/bin/sh
# build the instruction cache testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module icache_tb \
    -f icache.f -o icache_sim; then
  echo "build failed"
  exit 1
fi

# a failing assertion must not stop the run before the report
out=$(./obj_dir/icache_sim +verilator+error+limit+1000)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1
